// ==== adc_fe_pkg.sv ====
`default_nettype none

package adc_fe_pkg;

   localparam int ADC_W = 12;  // adc sample width
   localparam int CNT_W = 16;  // offset and length counts
   localparam int REG_W = 8;   // register data width

   // register map, one byte per address
   localparam logic [7:0] ADDR_SETTINGS  = 8'h00;
   localparam logic [7:0] ADDR_STATUS    = 8'h01;
   localparam logic [7:0] ADDR_LEVEL_LO  = 8'h02;
   localparam logic [7:0] ADDR_LEVEL_HI  = 8'h03;
   localparam logic [7:0] ADDR_OFFSET_LO = 8'h04;
   localparam logic [7:0] ADDR_OFFSET_HI = 8'h05;
   localparam logic [7:0] ADDR_LENGTH_LO = 8'h06;
   localparam logic [7:0] ADDR_LENGTH_HI = 8'h07;

   // capture control states
   localparam int ST_W = 3;
   localparam logic [ST_W-1:0] ST_IDLE     = 3'd0;
   localparam logic [ST_W-1:0] ST_ARMED    = 3'd1;
   localparam logic [ST_W-1:0] ST_WAIT_INA = 3'd2;  // waiting for inactive pin
   localparam logic [ST_W-1:0] ST_OFFSET   = 3'd3;
   localparam logic [ST_W-1:0] ST_CAPTURE  = 3'd4;

   typedef logic [ADC_W-1:0] sample_t;

   // settings byte, msb first
   typedef struct packed {
      logic [2:0] spare;      // read as zero
      logic       trig_now;   // self-clearing
      logic       arm;
      logic       trig_wait;  // 1 = wait for inactive trigger first
      logic       trig_high;  // 1 = trigger on high level
      logic       use_adc;    // 1 = adc input, 0 = test counter
   } settings_bits_t;

   typedef union packed {
      logic [REG_W-1:0] raw;
      settings_bits_t   bits;
   } settings_u;

   typedef struct packed {
      logic             trig_high;
      logic             trig_wait;
      sample_t          level;
      logic [CNT_W-1:0] offset;
      logic [CNT_W-1:0] length;
   } trig_cfg_t;

   typedef struct packed {
      logic [3:0] zero;
      logic       adc_trig_seen;
      logic       trigger_pin;
      logic       capture_idle;
      logic       armed;
   } fe_status_t;

endpackage

`default_nettype wire

// ==== adc_fe_regs.sv ====
`default_nettype none

module adc_fe_regs (
   input  logic                          ADC_clk_sample,
   input  logic                          reset,
   input  logic [adc_fe_pkg::REG_W-1:0]  reg_address_i,
   input  logic [adc_fe_pkg::REG_W-1:0]  reg_data_i,
   input  logic                          reg_write_i,
   input  logic                          reg_read_i,
   input  adc_fe_pkg::fe_status_t        status_i,
   output logic [adc_fe_pkg::REG_W-1:0]  reg_data_o,
   output adc_fe_pkg::trig_cfg_t         cfg_o,
   output logic                          use_adc_o,
   output logic                          arm_o,
   output logic                          trig_now_o
);
   import adc_fe_pkg::*;

   settings_u        settings_q;
   settings_u        wr_set;      // incoming byte seen as settings fields
   logic [REG_W-1:0] level_lo;
   logic [REG_W-1:0] level_hi;
   logic [REG_W-1:0] offset_lo;
   logic [REG_W-1:0] offset_hi;
   logic [REG_W-1:0] length_lo;
   logic [REG_W-1:0] length_hi;
   logic             trig_now_q;
   logic             wr_settings;

   assign wr_set.raw  = reg_data_i;
   assign wr_settings = reg_write_i && (reg_address_i == ADDR_SETTINGS);

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         settings_q.raw <= '0;
         level_lo       <= '0;
         level_hi       <= '0;
         offset_lo      <= '0;
         offset_hi      <= '0;
         length_lo      <= '0;
         length_hi      <= '0;
      end
      else if (reg_write_i) begin
         case (reg_address_i)
            ADDR_SETTINGS: begin
               // trig_now and spare bits are never stored
               settings_q.bits.spare     <= '0;
               settings_q.bits.trig_now  <= 1'b0;
               settings_q.bits.arm       <= wr_set.bits.arm;
               settings_q.bits.trig_wait <= wr_set.bits.trig_wait;
               settings_q.bits.trig_high <= wr_set.bits.trig_high;
               settings_q.bits.use_adc   <= wr_set.bits.use_adc;
            end
            ADDR_LEVEL_LO:  level_lo  <= reg_data_i;
            ADDR_LEVEL_HI:  level_hi  <= reg_data_i;
            ADDR_OFFSET_LO: offset_lo <= reg_data_i;
            ADDR_OFFSET_HI: offset_hi <= reg_data_i;
            ADDR_LENGTH_LO: length_lo <= reg_data_i;
            ADDR_LENGTH_HI: length_hi <= reg_data_i;
            default: ;  // status and unmapped ignore writes
         endcase
      end
   end

   // one-cycle force pulse
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         trig_now_q <= 1'b0;
      else
         trig_now_q <= wr_settings && wr_set.bits.trig_now;
   end

   // read data holds until the next read
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         reg_data_o <= '0;
      else if (reg_read_i) begin
         case (reg_address_i)
            ADDR_SETTINGS:  reg_data_o <= settings_q.raw;
            ADDR_STATUS:    reg_data_o <= status_i;
            ADDR_LEVEL_LO:  reg_data_o <= level_lo;
            ADDR_LEVEL_HI:  reg_data_o <= level_hi;
            ADDR_OFFSET_LO: reg_data_o <= offset_lo;
            ADDR_OFFSET_HI: reg_data_o <= offset_hi;
            ADDR_LENGTH_LO: reg_data_o <= length_lo;
            ADDR_LENGTH_HI: reg_data_o <= length_hi;
            default:        reg_data_o <= '0;
         endcase
      end
   end

   assign cfg_o.trig_high = settings_q.bits.trig_high;
   assign cfg_o.trig_wait = settings_q.bits.trig_wait;
   assign cfg_o.level     = {level_hi[ADC_W-REG_W-1:0], level_lo};  // upper nibble unused
   assign cfg_o.offset    = {offset_hi, offset_lo};
   assign cfg_o.length    = {length_hi, length_lo};

   assign use_adc_o  = settings_q.bits.use_adc;
   assign arm_o      = settings_q.bits.arm;
   assign trig_now_o = trig_now_q;

endmodule

`default_nettype wire

// ==== adc_sample_path.sv ====
`default_nettype none

module adc_sample_path (
   input  logic                ADC_clk_sample,
   input  logic                reset,
   input  adc_fe_pkg::sample_t adc_data_i,
   input  logic                use_adc_i,
   output adc_fe_pkg::sample_t sample_o
);
   import adc_fe_pkg::*;

   sample_t test_cnt;  // free-running test pattern

   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         test_cnt <= '0;
      else
         test_cnt <= test_cnt + 1'b1;
   end

   // one cycle of latency to the trigger logic
   always_ff @(posedge ADC_clk_sample) begin
      sample_o <= use_adc_i ? adc_data_i : test_cnt;
   end

endmodule

`default_nettype wire

// ==== adc_level_trigger.sv ====
`default_nettype none

module adc_level_trigger (
   input  logic                ADC_clk_sample,
   input  logic                reset,
   input  adc_fe_pkg::sample_t sample_i,
   input  adc_fe_pkg::sample_t level_i,
   input  logic                armed_ready_i,
   output logic                trigger_adc_o,
   output logic                seen_o
);
   import adc_fe_pkg::*;

   logic armed_ready_r;
   logic allowed;
   logic arm_rise;
   logic hit;

   assign arm_rise = armed_ready_i && !armed_ready_r;

   // level msb picks the compare direction
   assign hit = level_i[ADC_W-1] ? (sample_i > level_i) : (sample_i < level_i);

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         armed_ready_r <= 1'b0;
         allowed       <= 1'b0;
         trigger_adc_o <= 1'b0;
         seen_o        <= 1'b0;
      end
      else begin
         armed_ready_r <= armed_ready_i;
         trigger_adc_o <= allowed && hit;

         // single shot per arm
         if (allowed && hit)
            allowed <= 1'b0;
         else if (arm_rise)
            allowed <= 1'b1;

         if (allowed && hit)
            seen_o <= 1'b1;  // sticky until next arm
         else if (arm_rise)
            seen_o <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== capture_ctrl.sv ====
`default_nettype none

module capture_ctrl (
   input  logic                  ADC_clk_sample,
   input  logic                  reset,
   input  adc_fe_pkg::trig_cfg_t cfg_i,
   input  logic                  arm_i,
   input  logic                  trig_now_i,
   input  logic                  dut_trigger_i,
   output logic                  armed_o,
   output logic                  armed_ready_o,
   output logic                  capture_active_o
);
   import adc_fe_pkg::*;

   logic [ST_W-1:0]  state;
   logic [CNT_W-1:0] cnt;      // shared by offset and length phases
   logic [CNT_W-1:0] len_m1;
   logic             arm_r;
   logic             arm_rise;
   logic             pin_active;
   logic             trig_event;

   assign arm_rise   = arm_i && !arm_r;
   assign pin_active = (dut_trigger_i == cfg_i.trig_high);  // polarity match
   assign trig_event = (state == ST_ARMED) && (pin_active || trig_now_i);

   // zero length still gives one cycle
   assign len_m1 = (cfg_i.length == '0) ? '0 : cfg_i.length - 1'b1;

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         state <= ST_IDLE;
         cnt   <= '0;
         arm_r <= 1'b0;
      end
      else begin
         arm_r <= arm_i;
         case (state)
            ST_IDLE: begin
               if (arm_rise)
                  state <= cfg_i.trig_wait ? ST_WAIT_INA : ST_ARMED;
            end
            ST_WAIT_INA: begin
               if (!arm_i)
                  state <= ST_IDLE;   // disarmed
               else if (!pin_active)
                  state <= ST_ARMED;
            end
            ST_ARMED: begin
               if (trig_event) begin
                  if (cfg_i.offset == '0) begin
                     state <= ST_CAPTURE;
                     cnt   <= len_m1;
                  end
                  else begin
                     state <= ST_OFFSET;
                     cnt   <= cfg_i.offset;
                  end
               end
               else if (!arm_i)
                  state <= ST_IDLE;
            end
            ST_OFFSET: begin
               if (cnt <= 1) begin
                  state <= ST_CAPTURE;
                  cnt   <= len_m1;
               end
               else
                  cnt <= cnt - 1'b1;
            end
            ST_CAPTURE: begin
               if (cnt == '0)
                  state <= ST_IDLE;   // window done
               else
                  cnt <= cnt - 1'b1;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign armed_o          = (state == ST_ARMED) || (state == ST_WAIT_INA);
   assign armed_ready_o    = (state == ST_ARMED);
   assign capture_active_o = (state == ST_CAPTURE);

endmodule

`default_nettype wire

// ==== adc_frontend_top.sv ====
`default_nettype none

module adc_frontend_top (
   input  logic                         ADC_clk_sample,
   input  logic                         reset,
   input  adc_fe_pkg::sample_t          adc_data_i,
   input  logic                         dut_trigger_i,
   input  logic [adc_fe_pkg::REG_W-1:0] reg_address_i,
   input  logic [adc_fe_pkg::REG_W-1:0] reg_data_i,
   input  logic                         reg_write_i,
   input  logic                         reg_read_i,
   output logic [adc_fe_pkg::REG_W-1:0] reg_data_o,
   output logic                         trigger_adc_o,
   output logic                         capture_active_o,
   output logic                         armed_o
);
   import adc_fe_pkg::*;

   trig_cfg_t  cfg;
   fe_status_t status;
   sample_t    sample;
   logic       use_adc;
   logic       arm_req;
   logic       trig_now;
   logic       armed_ready;
   logic       adc_trig_seen;

   assign status.zero          = '0;
   assign status.adc_trig_seen = adc_trig_seen;
   assign status.trigger_pin   = dut_trigger_i;
   assign status.capture_idle  = !capture_active_o;
   assign status.armed         = armed_o;

   adc_fe_regs u_regs (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .reg_address_i  (reg_address_i),
      .reg_data_i     (reg_data_i),
      .reg_write_i    (reg_write_i),
      .reg_read_i     (reg_read_i),
      .status_i       (status),
      .reg_data_o     (reg_data_o),
      .cfg_o          (cfg),
      .use_adc_o      (use_adc),
      .arm_o          (arm_req),
      .trig_now_o     (trig_now)
   );

   adc_sample_path u_sample (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .use_adc_i      (use_adc),
      .sample_o       (sample)
   );

   adc_level_trigger u_level_trig (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .sample_i       (sample),
      .level_i        (cfg.level),
      .armed_ready_i  (armed_ready),
      .trigger_adc_o  (trigger_adc_o),
      .seen_o         (adc_trig_seen)
   );

   capture_ctrl u_capture (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .cfg_i            (cfg),
      .arm_i            (arm_req),
      .trig_now_i       (trig_now),
      .dut_trigger_i    (dut_trigger_i),
      .armed_o          (armed_o),
      .armed_ready_o    (armed_ready),
      .capture_active_o (capture_active_o)
   );

endmodule

`default_nettype wire

// ==== tb_adc_frontend_sva.sv ====
`default_nettype none

module adc_frontend_sva (
   input logic ADC_clk_sample,
   input logic reset,
   input logic trigger_i,
   input logic capture_active_i,
   input logic armed_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;  // read by the testbench at the end

   logic armed_seen;  // armed since the last capture window
   logic capture_q;

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         armed_seen <= 1'b0;
         capture_q  <= 1'b0;
      end
      else begin
         capture_q <= capture_active_i;
         if (armed_i)
            armed_seen <= 1'b1;
         else if (capture_q && !capture_active_i)
            armed_seen <= 1'b0;  // window over, next one needs a new arm
      end
   end

   // level trigger is a single-cycle pulse
   a_trig_single: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      trigger_i |=> !trigger_i)
      else begin
         $error("trigger_adc_o stayed high for more than one cycle");
         fail_cnt++;
      end

   // a capture window only opens after the block was armed
   a_capture_after_arm: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      $rose(capture_active_i) |-> armed_seen)
      else begin
         $error("capture_active_o rose without armed_o high before it");
         fail_cnt++;
      end

   a_reset_armed: assert property (@(posedge ADC_clk_sample) reset |=> !armed_i)
      else begin
         $error("armed_o high in the cycle after reset");
         fail_cnt++;
      end

endmodule

bind adc_frontend_top adc_frontend_sva u_sva (
   .ADC_clk_sample   (ADC_clk_sample),
   .reset            (reset),
   .trigger_i        (trigger_adc_o),
   .capture_active_i (capture_active_o),
   .armed_i          (armed_o)
);

`default_nettype wire

// ==== tb_adc_frontend.sv ====
`default_nettype none

module tb_adc_frontend;
   timeunit 1ns;
   timeprecision 100ps;
   import adc_fe_pkg::*;

   localparam int MAX_VEC = 128;

   logic             ADC_clk_sample;
   logic             reset;
   sample_t          adc_data;
   logic             dut_trigger;
   logic [REG_W-1:0] reg_address;
   logic [REG_W-1:0] reg_wdata;
   logic [REG_W-1:0] reg_rdata;
   logic             reg_write;
   logic             reg_read;
   logic             trigger_adc;
   logic             capture_active;
   logic             armed;

   logic [63:0] vec_op  [MAX_VEC];
   logic [31:0] vec_a   [MAX_VEC];
   logic [31:0] vec_b   [MAX_VEC];
   logic [31:0] vec_exp [MAX_VEC];
   int n_vec = 0;
   int cycles = 0;
   int cycle_limit = 0;  // armed once vectors are loaded
   int n_checks = 0;
   int n_errors = 0;
   int test_errors = 0;
   int n_tests = 0;
   logic exp_pulse = 1'b1;  // compare result of the last random sample

   adc_frontend_top u_adc_frontend_top (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .adc_data_i       (adc_data),
      .dut_trigger_i    (dut_trigger),
      .reg_address_i    (reg_address),
      .reg_data_i       (reg_wdata),
      .reg_write_i      (reg_write),
      .reg_read_i       (reg_read),
      .reg_data_o       (reg_rdata),
      .trigger_adc_o    (trigger_adc),
      .capture_active_o (capture_active),
      .armed_o          (armed)
   );

   initial begin
      ADC_clk_sample = 1'b0;
      forever #50 ADC_clk_sample = ~ADC_clk_sample;
   end

   always @(posedge ADC_clk_sample) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles > cycle_limit) begin
         $display("timeout: no result after %0d cycles, the DUT stopped responding", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   // worst-case cycles each opcode may take
   function automatic int op_cycles(input logic [63:0] op, input logic [31:0] a);
      case (op)
         "wr", "rd":                   return 2;
         "smp", "pin":                 return 1;
         "act":                        return 2 * int'(a);
         "pls", "lat", "noact", "arm": return int'(a);
         default:                      return 0;
      endcase
   endfunction

   task automatic load_vectors(output bit ok);
      int fd;
      int code;
      int budget;
      logic [63:0] op;
      logic [8*128-1:0] rest;
      budget = 0;
      fd = $fopen("adc_frontend_vectors.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         code = $fscanf(fd, "%s", op);
         while (code == 1 && n_vec < MAX_VEC) begin
            if (op == "#")
               code = $fgets(rest, fd);  // skip comment line
            else begin
               code = $fscanf(fd, "%h %h %h", vec_a[n_vec], vec_b[n_vec], vec_exp[n_vec]);
               vec_op[n_vec] = op;
               budget += op_cycles(op, vec_a[n_vec]);
               n_vec++;
            end
            code = $fscanf(fd, "%s", op);
         end
         $fclose(fd);
         cycle_limit = 2 * budget + 200;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         test_errors++;
         $display("ERR %s exp=%h got=%h", name, exp, got);
      end
   endtask

   task automatic report_failure(input string msg);
      n_errors++;
      test_errors++;
      $display("%s", msg);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(posedge ADC_clk_sample);
      reg_address <= addr;
      reg_wdata   <= data;
      reg_write   <= 1'b1;
      @(posedge ADC_clk_sample);
      reg_write   <= 1'b0;
   endtask

   task automatic read_check(input logic [7:0] addr, input logic [7:0] exp);
      @(posedge ADC_clk_sample);
      reg_address <= addr;
      reg_read    <= 1'b1;
      @(posedge ADC_clk_sample);
      reg_read    <= 1'b0;
      @(negedge ADC_clk_sample);
      check_value("reg_data_o", exp, reg_rdata);
   endtask

   // mode 1 random above level, 2 random below, else fixed
   task automatic drive_sample(input logic [31:0] v, input logic [31:0] mode);
      sample_t s;
      case (mode)
         1:       s = sample_t'(v + 1 + ($urandom % (32'hfff - v)));
         2:       s = sample_t'($urandom % v);
         default: s = sample_t'(v);
      endcase
      // level bit 11 set means greater-than, clear means less-than
      if (mode != 0) begin
         if (v[ADC_W-1])
            exp_pulse = (s > sample_t'(v));
         else
            exp_pulse = (s < sample_t'(v));
      end
      @(posedge ADC_clk_sample);
      adc_data <= s;
   endtask

   task automatic drive_pin(input logic v);
      @(posedge ADC_clk_sample);
      dut_trigger <= v;
   endtask

   task automatic count_pulses(input int n, input logic [31:0] exp);
      int cnt;
      cnt = 0;
      repeat (n) begin
         @(posedge ADC_clk_sample);
         @(negedge ADC_clk_sample);
         if (trigger_adc)
            cnt++;
      end
      check_value("trigger_adc_o pulses", exp, cnt);
   endtask

   task automatic pulse_latency(input int n, input logic [31:0] exp);
      int  k;
      bit  found;
      k = 0;
      found = 0;
      while (!found && k < n) begin
         @(posedge ADC_clk_sample);
         k++;
         @(negedge ADC_clk_sample);
         found = trigger_adc;
      end
      if (found && exp_pulse)
         check_value("trigger_adc_o latency", exp, k);
      else if (exp_pulse)
         report_failure("no trigger pulse arrived within the wait window");
      else if (found)
         report_failure("trigger pulse for a sample on the wrong side of the level");
   endtask

   task automatic capture_window(input int n, input logic [31:0] delay, input logic [31:0] len_exp);
      int k;
      int len;
      k = 0;
      len = 0;
      while (!capture_active && k < n) begin
         @(posedge ADC_clk_sample);
         k++;
         @(negedge ADC_clk_sample);
         if (k == 1)
            check_value("armed_o", 0, armed);  // drops on the trigger event
      end
      if (!capture_active)
         report_failure("capture window never opened after the trigger");
      else begin
         check_value("capture_active_o delay", delay, k);
         while (capture_active && len < n) begin
            len++;
            @(posedge ADC_clk_sample);
            @(negedge ADC_clk_sample);
         end
         check_value("capture_active_o length", len_exp, len);
      end
   endtask

   task automatic no_capture(input int n);
      int cnt;
      cnt = 0;
      repeat (n) begin
         @(posedge ADC_clk_sample);
         @(negedge ADC_clk_sample);
         if (capture_active)
            cnt++;
      end
      check_value("capture_active_o", 0, cnt);
   endtask

   task automatic armed_after(input int n, input logic [31:0] exp);
      repeat (n) @(posedge ADC_clk_sample);
      @(negedge ADC_clk_sample);
      check_value("armed_o", exp, armed);
   endtask

   task automatic run_vector(input int i);
      case (vec_op[i])
         "wr":    write_reg(vec_a[i][7:0], vec_b[i][7:0]);
         "rd":    read_check(vec_a[i][7:0], vec_exp[i][7:0]);
         "smp":   drive_sample(vec_a[i], vec_b[i]);
         "pin":   drive_pin(vec_a[i][0]);
         "pls":   count_pulses(int'(vec_a[i]), vec_exp[i]);
         "lat":   pulse_latency(int'(vec_a[i]), vec_exp[i]);
         "act":   capture_window(int'(vec_a[i]), vec_b[i], vec_exp[i]);
         "noact": no_capture(int'(vec_a[i]));
         "arm":   armed_after(int'(vec_a[i]), vec_exp[i]);
         "end": begin
            n_tests++;
            $display("test %0d finished with %0d errors", vec_a[i], test_errors);
            test_errors = 0;
         end
         default: report_failure("unknown opcode in the vector file");
      endcase
   endtask

   initial begin
      bit ok;
      int sva_fails;
      reset       = 1'b1;
      adc_data    = '0;
      dut_trigger = 1'b0;
      reg_address = '0;
      reg_wdata   = '0;
      reg_write   = 1'b0;
      reg_read    = 1'b0;
      void'($urandom(32'h7be8c83d));
      load_vectors(ok);
      if (!ok) begin
         $display("could not open adc_frontend_vectors.txt");
         $display("Simulation failed");
         $finish;
      end
      else begin
         repeat (5) @(posedge ADC_clk_sample);
         reset <= 1'b0;
         for (int i = 0; i < n_vec; i++)
            run_vector(i);
         sva_fails = u_adc_frontend_top.u_sva.fail_cnt;
         $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                  n_tests, n_checks, n_errors, sva_fails);
         if (n_errors == 0 && sva_fails == 0)
            $display("Simulation passed");
         else
            $display("Simulation failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== adc_frontend_vectors.txt ====
# op a b exp, all hex: wr addr data, rd addr exp, smp value mode hit, pin level
# pls/lat/noact/arm cycles, act maxcycles delay length, end test id
rd 01 0 02
wr 02 5a 0
wr 03 03 0
wr 05 12 0
wr 06 cd 0
wr 00 17 0
rd 02 0 5a
rd 03 0 03
rd 05 0 12
rd 06 0 cd
rd 00 0 07
rd 20 0 00
end 1 0 0
wr 00 02 0
wr 02 10 0
wr 03 08 0
wr 00 0a 0
pls 1010 0 1
rd 01 0 0b
wr 00 02 0
wr 00 0a 0
pls 1010 0 1
end 2 0 0
wr 00 03 0
smp 000 0 0
wr 02 00 0
wr 03 09 0
wr 00 0b 0
pls 6 0 0
smp 900 1 1
lat 8 0 2
smp 900 1 1
pls 6 0 0
wr 00 03 0
smp fff 0 0
wr 03 03 0
wr 00 0b 0
pls 6 0 0
smp 300 2 1
lat 8 0 2
end 3 0 0
wr 00 03 0
wr 04 03 0
wr 05 00 0
wr 06 05 0
wr 00 0b 0
arm 3 0 1
pin 1 0 0
act 14 4 5
end 4 0 0
wr 00 03 0
wr 00 0f 0
arm 2 0 1
noact 8 0 0
pin 0 0 0
noact 4 0 0
pin 1 0 0
act 14 4 5
wr 00 03 0
pin 0 0 0
wr 00 0b 0
noact 4 0 0
wr 00 1b 0
act 14 4 5
wr 00 01 0
pin 1 0 0
wr 00 09 0
noact 4 0 0
pin 0 0 0
act 14 4 5
end 5 0 0

// ==== compile.f ====
adc_fe_pkg.sv
adc_fe_regs.sv
adc_sample_path.sv
adc_level_trigger.sv
capture_ctrl.sv
adc_frontend_top.sv
tb_adc_frontend_sva.sv
tb_adc_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_adc_frontend
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the pipeline status comes from awk, set by the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^Simulation passed$$/ { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
